// File: src/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define XLEN		32
`define NREGS		32
`define RADDR_W		5					// log2 of NREGS
`define WEN_W		(`XLEN / 8)			// byte write enables
`define RESET_PC	32'h0000_0000

`endif

// File: src/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef enum logic [6:0] {
		OP		= 7'b0110011,
		OP_IMM	= 7'b0010011,
		LUI		= 7'b0110111,
		LOAD	= 7'b0000011,
		STORE	= 7'b0100011,
		BRANCH	= 7'b1100011,
		JAL		= 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLT, PASS_B
	} alu_op_e;

	// funct3 / funct7 values of the supported subset
	localparam logic [2:0] F3_ADD_SUB	= 3'b000;
	localparam logic [2:0] F3_SLT		= 3'b010;
	localparam logic [2:0] F3_XOR		= 3'b100;
	localparam logic [2:0] F3_OR		= 3'b110;
	localparam logic [2:0] F3_AND		= 3'b111;
	localparam logic [2:0] F3_ADDI		= 3'b000;
	localparam logic [2:0] F3_LW		= 3'b010;
	localparam logic [2:0] F3_SW		= 3'b010;
	localparam logic [2:0] F3_BEQ		= 3'b000;
	localparam logic [2:0] F3_BNE		= 3'b001;
	localparam logic [6:0] F7_BASE		= 7'b0000000;
	localparam logic [6:0] F7_SUB		= 7'b0100000;

	//////////////////////////////////////////////////
	// instruction formats

	typedef struct packed {
		logic	[6:0]	funct7;
		logic	[4:0]	rs2;
		logic	[4:0]	rs1;
		logic	[2:0]	funct3;
		logic	[4:0]	rd;
		opcode_e		opcode;
	} r_type_t;

	typedef struct packed {
		logic	[11:0]	imm;
		logic	[4:0]	rs1;
		logic	[2:0]	funct3;
		logic	[4:0]	rd;
		opcode_e		opcode;
	} i_type_t;

	typedef struct packed {
		logic	[6:0]	imm_hi;
		logic	[4:0]	rs2;
		logic	[4:0]	rs1;
		logic	[2:0]	funct3;
		logic	[4:0]	imm_lo;
		opcode_e		opcode;
	} s_type_t;

	typedef struct packed {
		logic			imm12;
		logic	[5:0]	imm10_5;
		logic	[4:0]	rs2;
		logic	[4:0]	rs1;
		logic	[2:0]	funct3;
		logic	[3:0]	imm4_1;
		logic			imm11;
		opcode_e		opcode;
	} b_type_t;

	typedef struct packed {
		logic	[19:0]	imm;
		logic	[4:0]	rd;
		opcode_e		opcode;
	} u_type_t;

	typedef struct packed {
		logic			imm20;
		logic	[9:0]	imm10_1;
		logic			imm11;
		logic	[7:0]	imm19_12;
		logic	[4:0]	rd;
		opcode_e		opcode;
	} j_type_t;

	typedef union packed {
		r_type_t	r;
		i_type_t	i;
		s_type_t	s;
		b_type_t	b;
		u_type_t	u;
		j_type_t	j;
	} inst_u;

endpackage

`default_nettype wire

// File: src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	typedef enum logic [1:0] {
		NONE,
		LOAD,
		STORE
	} mem_op_e;

	// decoded control, travels with the instruction into execute
	typedef struct packed {
		isa_pkg::alu_op_e	alu_op;
		logic				sel_imm;	// operand b from imm
		logic				sel_pc;		// operand a from pc
		mem_op_e			mem_op;
		logic				rd_write;
		logic				jump;
		logic				branch;
		logic				branch_ne;
	} ctrl_t;

endpackage

`default_nettype wire

// File: src/stage_ifs.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

// fetch -> decode
interface if_id_if;
	logic	[`XLEN-1:0]	pc;
	logic	[`XLEN-1:0]	ir;
	logic				valid;

	modport source (output pc, ir, valid);
	modport sink (input pc, ir, valid);
endinterface

// decode -> execute
interface id_ex_if;
	logic	[`XLEN-1:0]		pc;
	logic	[`XLEN-1:0]		imm;
	pipe_pkg::ctrl_t		ctrl;
	logic	[`RADDR_W-1:0]	rs1_addr;
	logic	[`XLEN-1:0]		rs1_data;
	logic					rs1_use;
	logic	[`RADDR_W-1:0]	rs2_addr;
	logic	[`XLEN-1:0]		rs2_data;
	logic					rs2_use;
	logic	[`RADDR_W-1:0]	rd_addr;
	logic					valid;

	modport source (output pc, imm, ctrl, rs1_addr, rs1_data, rs1_use,
		rs2_addr, rs2_data, rs2_use, rd_addr, valid);
	modport sink (input pc, imm, ctrl, rs1_addr, rs1_data, rs1_use,
		rs2_addr, rs2_data, rs2_use, rd_addr, valid);
endinterface

// execute -> memory
interface ex_mem_if;
	logic	[`RADDR_W-1:0]	rd_addr;
	logic	[`XLEN-1:0]		rd_data;
	logic					rd_write;
	logic					is_load;
	logic					valid;

	modport source (output rd_addr, rd_data, rd_write, is_load, valid);
	modport sink (input rd_addr, rd_data, rd_write, is_load, valid);
endinterface

// writeback bus, also the late forwarding path
interface wb_if;
	logic	[`RADDR_W-1:0]	rd_addr;
	logic	[`XLEN-1:0]		rd_data;
	logic					rd_write;

	modport source (output rd_addr, rd_data, rd_write);
	modport sink (input rd_addr, rd_data, rd_write);
endinterface

`default_nettype wire

// File: src/fetch_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_stage
(
	input	logic				clk,
	input	logic				reset,
	input	logic				stall,
	input	logic				flush,
	input	logic	[`XLEN-1:0]	jump_addr,

	output	logic	[`XLEN-1:0]	imem_addr,
	output	logic				imem_ena,
	input	logic	[`XLEN-1:0]	imem_din,

	if_id_if.source				fd
);

	logic	[`XLEN-1:0]	pc;

	assign imem_addr	= pc;
	assign imem_ena		= !stall;	// memory keeps its word while we stall

	// the memory output register is the instruction register
	assign fd.ir		= imem_din;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc			<= `RESET_PC;
			fd.valid	<= 1'b0;
		end else if (flush) begin
			pc			<= jump_addr;
			fd.valid	<= 1'b0;	// word in flight is from the wrong path
		end else if (!stall) begin
			pc			<= pc + `XLEN'd4;
			fd.valid	<= 1'b1;
		end
	end

	// pc of the word now being returned
	always_ff @(posedge clk) begin
		if (!stall)
			fd.pc <= pc;
	end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module decode_stage
(
	input	logic	clk,
	input	logic	reset,
	input	logic	stall,
	input	logic	flush,

	if_id_if.sink	fd,
	id_ex_if.source	de,
	wb_if.sink		wb
);

	logic	[`XLEN-1:0]		regs [`NREGS];

	isa_pkg::inst_u			inst;
	pipe_pkg::ctrl_t		ctrl;
	logic	[`XLEN-1:0]		imm;
	logic	[`XLEN-1:0]		imm_i;
	logic	[`XLEN-1:0]		imm_s;
	logic	[`XLEN-1:0]		imm_b;
	logic	[`XLEN-1:0]		imm_u;
	logic	[`XLEN-1:0]		imm_j;
	logic					rs1_use;
	logic					rs2_use;
	logic					wr;
	logic					legal;
	logic	[`RADDR_W-1:0]	rs1_sel;
	logic	[`RADDR_W-1:0]	rs2_sel;

	assign inst = fd.ir;

	assign imm_i = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{(`XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	assign imm_b = {{(`XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
		inst.b.imm4_1, 1'b0};
	assign imm_u = {inst.u.imm, 12'b0};
	assign imm_j = {{(`XLEN-20){inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
		inst.j.imm10_1, 1'b0};

	//////////////////////////////////////////////////
	// decoder

	always_comb begin
		ctrl	= '0;
		imm		= '0;
		rs1_use	= 1'b0;
		rs2_use	= 1'b0;
		wr		= 1'b0;
		legal	= 1'b1;
		case (inst.r.opcode)
			isa_pkg::OP: begin
				rs1_use	= 1'b1;
				rs2_use	= 1'b1;
				wr		= 1'b1;
				legal	= inst.r.funct7 == isa_pkg::F7_BASE ||
					(inst.r.funct3 == isa_pkg::F3_ADD_SUB && inst.r.funct7 == isa_pkg::F7_SUB);
				case (inst.r.funct3)
					isa_pkg::F3_ADD_SUB: begin
						if (inst.r.funct7 == isa_pkg::F7_SUB)
							ctrl.alu_op = isa_pkg::SUB;
						else
							ctrl.alu_op = isa_pkg::ADD;
					end
					isa_pkg::F3_SLT:	ctrl.alu_op = isa_pkg::SLT;
					isa_pkg::F3_XOR:	ctrl.alu_op = isa_pkg::XOR;
					isa_pkg::F3_OR:		ctrl.alu_op = isa_pkg::OR;
					isa_pkg::F3_AND:	ctrl.alu_op = isa_pkg::AND;
					default:			legal = 1'b0;	// shifts, sltu
				endcase
			end
			isa_pkg::OP_IMM: begin	// addi only
				legal			= inst.i.funct3 == isa_pkg::F3_ADDI;
				ctrl.sel_imm	= 1'b1;
				rs1_use			= 1'b1;
				wr				= 1'b1;
				imm				= imm_i;
			end
			isa_pkg::LUI: begin
				ctrl.alu_op		= isa_pkg::PASS_B;
				ctrl.sel_imm	= 1'b1;
				wr				= 1'b1;
				imm				= imm_u;
			end
			isa_pkg::LOAD: begin
				legal			= inst.i.funct3 == isa_pkg::F3_LW;
				ctrl.sel_imm	= 1'b1;
				ctrl.mem_op		= pipe_pkg::LOAD;
				rs1_use			= 1'b1;
				wr				= 1'b1;
				imm				= imm_i;
			end
			isa_pkg::STORE: begin
				legal			= inst.s.funct3 == isa_pkg::F3_SW;
				ctrl.sel_imm	= 1'b1;
				ctrl.mem_op		= pipe_pkg::STORE;
				rs1_use			= 1'b1;
				rs2_use			= 1'b1;
				imm				= imm_s;
			end
			isa_pkg::BRANCH: begin
				legal = inst.b.funct3 == isa_pkg::F3_BEQ || inst.b.funct3 == isa_pkg::F3_BNE;
				ctrl.branch		= 1'b1;
				ctrl.branch_ne	= inst.b.funct3 == isa_pkg::F3_BNE;
				rs1_use			= 1'b1;
				rs2_use			= 1'b1;
				imm				= imm_b;
			end
			isa_pkg::JAL: begin
				ctrl.jump		= 1'b1;
				ctrl.sel_pc		= 1'b1;	// link = pc + 4
				wr				= 1'b1;
				imm				= imm_j;
			end
			default: legal = 1'b0;
		endcase

		// anything not decoded runs as a no-op
		if (!legal) begin
			ctrl	= '0;
			rs1_use	= 1'b0;
			rs2_use	= 1'b0;
			wr		= 1'b0;
		end
		ctrl.rd_write = wr && inst.r.rd != '0;
	end

	//////////////////////////////////////////////////
	// register file

	function automatic logic [`XLEN-1:0] rf_read(input logic [`RADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (wb.rd_write && wb.rd_addr == addr)
			return wb.rd_data;	// write-through
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (wb.rd_write)
			regs[wb.rd_addr] <= wb.rd_data;
	end

	// re-read own sources while stalled so late writebacks are not missed
	assign rs1_sel = stall ? de.rs1_addr : inst.r.rs1;
	assign rs2_sel = stall ? de.rs2_addr : inst.r.rs2;

	//////////////////////////////////////////////////
	// id/ex register

	always_ff @(posedge clk) begin
		if (reset) begin
			de.valid	<= 1'b0;
			de.ctrl		<= '0;
		end else if (flush) begin
			de.valid	<= 1'b0;
		end else if (!stall) begin
			de.valid	<= fd.valid;
			de.ctrl		<= ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			de.pc		<= fd.pc;
			de.imm		<= imm;
			de.rs1_addr	<= inst.r.rs1;
			de.rs1_use	<= rs1_use;
			de.rs2_addr	<= inst.r.rs2;
			de.rs2_use	<= rs2_use;
			de.rd_addr	<= inst.r.rd;
		end
		de.rs1_data	<= rf_read(rs1_sel);
		de.rs2_data	<= rf_read(rs2_sel);
	end

	a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
		de.valid && de.ctrl.rd_write |-> de.rd_addr != '0);

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module execute_stage
(
	input	logic				clk,
	input	logic				reset,
	input	logic				bubble,

	id_ex_if.sink				de,
	ex_mem_if.source			em,
	wb_if.sink					wb,

	output	logic				jump_taken,
	output	logic	[`XLEN-1:0]	jump_addr,

	output	logic	[`XLEN-1:0]	dmem_addr,
	output	logic	[`XLEN-1:0]	dmem_dout,
	output	logic				dmem_ena,
	output	logic	[`WEN_W-1:0]	dmem_wen
);

	logic				issue;
	logic	[`XLEN-1:0]	rs1_val;
	logic	[`XLEN-1:0]	rs2_val;
	logic	[`XLEN-1:0]	op_a;
	logic	[`XLEN-1:0]	op_b;
	logic	[`XLEN-1:0]	alu_out;
	logic				taken;

	// ex/mem result first, then writeback, then the register file copy
	function automatic logic [`XLEN-1:0] fwd(input logic [`RADDR_W-1:0] addr,
		input logic [`XLEN-1:0] data);
		if (em.rd_write && em.rd_addr == addr)
			return em.rd_data;
		if (wb.rd_write && wb.rd_addr == addr)
			return wb.rd_data;
		return data;
	endfunction

	assign issue	= de.valid && !bubble;
	assign rs1_val	= fwd(de.rs1_addr, de.rs1_data);
	assign rs2_val	= fwd(de.rs2_addr, de.rs2_data);

	assign op_a = de.ctrl.sel_pc ? de.pc : rs1_val;
	assign op_b = de.ctrl.jump ? `XLEN'd4 : (de.ctrl.sel_imm ? de.imm : rs2_val);

	always_comb begin
		case (de.ctrl.alu_op)
			isa_pkg::ADD:		alu_out = op_a + op_b;
			isa_pkg::SUB:		alu_out = op_a - op_b;
			isa_pkg::AND:		alu_out = op_a & op_b;
			isa_pkg::OR:		alu_out = op_a | op_b;
			isa_pkg::XOR:		alu_out = op_a ^ op_b;
			isa_pkg::SLT:		alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			isa_pkg::PASS_B:	alu_out = op_b;
			default:			alu_out = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// branch resolution, redirect in the same cycle

	assign taken		= de.ctrl.branch && ((rs1_val == rs2_val) ^ de.ctrl.branch_ne);
	assign jump_taken	= issue && (de.ctrl.jump || taken);
	assign jump_addr	= de.pc + de.imm;

	// data memory request
	assign dmem_ena		= issue && de.ctrl.mem_op != pipe_pkg::NONE;
	assign dmem_addr	= alu_out;
	assign dmem_dout	= rs2_val;
	assign dmem_wen		= {`WEN_W{issue && de.ctrl.mem_op == pipe_pkg::STORE}};

	//////////////////////////////////////////////////
	// ex/mem register

	always_ff @(posedge clk) begin
		if (reset) begin
			em.valid	<= 1'b0;
			em.rd_write	<= 1'b0;
			em.is_load	<= 1'b0;
		end else begin
			em.valid	<= issue;	// a bubble enters as invalid
			em.rd_write	<= issue && de.ctrl.rd_write;
			em.is_load	<= issue && de.ctrl.mem_op == pipe_pkg::LOAD;
		end
	end

	always_ff @(posedge clk) begin
		em.rd_addr	<= de.rd_addr;
		em.rd_data	<= alu_out;	// address for loads
	end

	a_wen_ena: assert property (@(posedge clk) disable iff (reset)
		dmem_wen != '0 |-> dmem_ena);

	// the shadow of a taken branch is always squashed
	a_no_back_to_back: assert property (@(posedge clk) disable iff (reset)
		jump_taken |=> !jump_taken);

endmodule

`default_nettype wire

// File: src/memory_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module memory_stage
(
	input	logic				clk,
	input	logic				reset,

	ex_mem_if.sink				em,
	input	logic	[`XLEN-1:0]	dmem_din,

	wb_if.source				wb
);

	logic	[`XLEN-1:0]	result;

	// load data arrives this cycle from the request made in execute
	assign result = em.is_load ? dmem_din : em.rd_data;

	//////////////////////////////////////////////////
	// writeback register

	always_ff @(posedge clk) begin
		if (reset)
			wb.rd_write <= 1'b0;
		else
			wb.rd_write <= em.valid && em.rd_write;
	end

	always_ff @(posedge clk) begin
		wb.rd_addr	<= em.rd_addr;
		wb.rd_data	<= result;
	end

	a_wb_nonzero: assert property (@(posedge clk) disable iff (reset)
		wb.rd_write |-> wb.rd_addr != '0);

endmodule

`default_nettype wire

// File: src/core_pipeline.sv
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module core_pipeline
(
	input	logic				clk,
	input	logic				reset,

	output	logic	[`XLEN-1:0]	imem_addr,
	input	logic	[`XLEN-1:0]	imem_din,
	output	logic				imem_ena,

	output	logic	[`XLEN-1:0]	dmem_addr,
	output	logic	[`XLEN-1:0]	dmem_dout,
	input	logic	[`XLEN-1:0]	dmem_din,
	output	logic				dmem_ena,
	output	logic	[`WEN_W-1:0]	dmem_wen
);

	if_id_if	fd_bus();
	id_ex_if	de_bus();
	ex_mem_if	em_bus();
	wb_if		wb_bus();

	logic				jump_taken;
	logic	[`XLEN-1:0]	jump_addr;
	logic				ld_use_rs1;
	logic				ld_use_rs2;
	logic				stall;
	logic				bubble;
	logic				flush;

	//////////////////////////////////////////////////
	// hazards

	// source in id/ex waits on a load sitting in ex/mem
	assign ld_use_rs1 = de_bus.rs1_use && |de_bus.rs1_addr && em_bus.is_load &&
		em_bus.rd_write && de_bus.rs1_addr == em_bus.rd_addr;
	assign ld_use_rs2 = de_bus.rs2_use && |de_bus.rs2_addr && em_bus.is_load &&
		em_bus.rd_write && de_bus.rs2_addr == em_bus.rd_addr;

	assign stall	= de_bus.valid && (ld_use_rs1 || ld_use_rs2);
	assign bubble	= stall;
	assign flush	= jump_taken;

	fetch_stage fetch_inst (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.jump_addr(jump_addr),
		.imem_addr(imem_addr),
		.imem_ena(imem_ena),
		.imem_din(imem_din),
		.fd(fd_bus)
	);

	decode_stage decode_inst (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.fd(fd_bus),
		.de(de_bus),
		.wb(wb_bus)
	);

	execute_stage execute_inst (
		.clk(clk),
		.reset(reset),
		.bubble(bubble),
		.de(de_bus),
		.em(em_bus),
		.wb(wb_bus),
		.jump_taken(jump_taken),
		.jump_addr(jump_addr),
		.dmem_addr(dmem_addr),
		.dmem_dout(dmem_dout),
		.dmem_ena(dmem_ena),
		.dmem_wen(dmem_wen)
	);

	memory_stage memory_inst (
		.clk(clk),
		.reset(reset),
		.em(em_bus),
		.dmem_din(dmem_din),
		.wb(wb_bus)
	);

endmodule

`default_nettype wire

// File: verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////
// random numbers

// galois lfsr, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int k = 0; k < n; k++) begin
		if (lfsr[0])
			lfsr = (lfsr >> 1) ^ 32'hD000_0001;
		else
			lfsr = lfsr >> 1;
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

function automatic logic [4:0] rnd_reg();
	logic [31:0] r;
	r = lfsr_bits(5);
	if (r[4:0] == 5'd0)
		return 5'd1;	// never target x0
	return r[4:0];
endfunction

// data ram contents, depends on every index bit
function automatic logic [31:0] fill_word(input logic [5:0] i);
	return {16'hD00D, 4'h0, i, i ^ 6'h2A};
endfunction

//////////////////////////////////////////////////
// encoders

function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs1,
	input logic [4:0] rs2);
	logic [31:0] r;
	logic [2:0] f3;
	r = lfsr_bits(4);
	case (r[2:0] % 3'd5)
		3'd0:		f3 = 3'b000;
		3'd1:		f3 = 3'b010;
		3'd2:		f3 = 3'b100;
		3'd3:		f3 = 3'b110;
		default:	f3 = 3'b111;
	endcase
	return {1'b0, r[3] && f3 == 3'b000, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [11:0] off);
	return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic ne, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

//////////////////////////////////////////////////
// program generator

function automatic int pick_kind(input int mode);
	logic [31:0] r;
	r = lfsr_bits(3);
	case (mode)
		M_ALU, M_DEP:	return int'(r[1:0] % 2'd3);
		M_LOAD:			return (r[1:0] == 2'd0) ? K_SW : ((r[1:0] == 2'd1) ? K_R : K_LW);
		M_CTRL: begin
			case (r[2:0] % 3'd5)
				3'd0:		return K_R;
				3'd1:		return K_ADDI;
				3'd2:		return K_SW;
				3'd3:		return K_BR;
				default:	return K_JAL;
			endcase
		end
		default:		return int'(r[2:0] % 3'd7);
	endcase
endfunction

function automatic void gen_program(input int mode);
	int p;
	int body_end;
	int kind;
	int skip;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] prev;
	logic [4:0] prev2;
	logic [31:0] r;
	p = 0;
	prev = 5'd1;
	prev2 = 5'd2;
	for (int i = 0; i < 256; i++)
		rom[i] = 32'h0;
	// known start value in every register
	for (int i = 1; i < 32; i++) begin
		rom[p] = {12'(lfsr_bits(12)), 5'd0, 3'b000, 5'(i), 7'b0010011};
		p++;
	end
	body_end = p + BODY_LEN;
	while (p < body_end) begin
		rd = rnd_reg();
		rs1 = (mode == M_DEP) ? prev : rnd_reg();
		rs2 = (mode == M_DEP) ? prev2 : rnd_reg();
		r = lfsr_bits(12);
		kind = pick_kind(mode);
		if (kind == K_LW && p + 1 >= body_end)
			kind = K_R;
		skip = 2 + int'(r[1:0]);
		if (skip > body_end - p)
			skip = body_end - p;
		case (kind)
			K_R:	rom[p] = enc_r(rd, rs1, rs2);
			K_ADDI:	rom[p] = {r[11:0], rs1, 3'b000, rd, 7'b0010011};
			K_LUI:	rom[p] = {r[11:0], 8'(lfsr_bits(8)), rd, 7'b0110111};
			K_LW: begin	// load, then use it at once
				rom[p] = {2'b00, r[7:0], 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
				p++;
				rom[p] = enc_r(rnd_reg(), rd, rs2);
			end
			K_SW:	rom[p] = enc_s(rs2, {2'b00, r[7:0], 2'b00});
			K_BR:	rom[p] = enc_b(r[2], rs1, r[3] ? rs1 : rs2, 13'(skip * 4));
			default: rom[p] = enc_j(rd, 21'(skip * 4));
		endcase
		if (kind <= K_LUI) begin
			prev2 = prev;
			prev = rd;
		end
		p++;
	end
	// dump every register, then spin
	for (int i = 1; i < 32; i++)
		rom[body_end + i - 1] = enc_s(5'(i), 12'(i * 4));
	rom[body_end + 31] = 32'h0000_006F;
endfunction

//////////////////////////////////////////////////
// isa model, fills the expected store list

function automatic void run_model();
	logic [31:0] x [32];
	logic [31:0] mram [64];
	logic [31:0] pc;
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	logic [31:0] addr;
	int steps;
	for (int i = 0; i < 32; i++)
		x[i] = '0;
	for (int i = 0; i < 64; i++)
		mram[i] = fill_word(6'(i));
	exp_addr.delete();
	exp_data.delete();
	pc = '0;
	steps = 0;
	w = rom[pc[9:2]];
	while (w != 32'h0000_006F && steps < 2000) begin
		a = x[w[19:15]];
		b = x[w[24:20]];
		res = '0;
		case (w[6:0])
			7'b0110011: begin
				case (w[14:12])
					3'b000:		res = w[30] ? a - b : a + b;
					3'b010:		res = {31'b0, $signed(a) < $signed(b)};
					3'b100:		res = a ^ b;
					3'b110:		res = a | b;
					default:	res = a & b;
				endcase
				x[w[11:7]] = res;
			end
			7'b0010011:	x[w[11:7]] = a + {{20{w[31]}}, w[31:20]};
			7'b0110111:	x[w[11:7]] = {w[31:12], 12'b0};
			7'b0000011: begin
				addr = a + {{20{w[31]}}, w[31:20]};
				x[w[11:7]] = mram[addr[7:2]];
			end
			7'b0100011: begin
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				mram[addr[7:2]] = b;
				exp_addr.push_back(addr);
				exp_data.push_back(b);
			end
			7'b1100011: begin
				if ((a == b) != w[12])
					pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0} - 32'd4;
			end
			default: begin	// jal
				x[w[11:7]] = pc + 32'd4;
				pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0} - 32'd4;
			end
		endcase
		x[0] = '0;
		pc = pc + 32'd4;
		w = rom[pc[9:2]];
		steps++;
	end
endfunction

`endif

// File: verif/tb_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_core;

	localparam int M_ALU = 0;
	localparam int M_DEP = 1;
	localparam int M_LOAD = 2;
	localparam int M_CTRL = 3;
	localparam int M_MIX = 4;
	localparam int K_R = 0;
	localparam int K_ADDI = 1;
	localparam int K_LUI = 2;
	localparam int K_LW = 3;
	localparam int K_SW = 4;
	localparam int K_BR = 5;
	localparam int K_JAL = 6;
	localparam int BODY_LEN = 48;

	logic			clk;
	logic			reset;
	logic	[31:0]	imem_addr;
	logic	[31:0]	imem_din;
	logic			imem_ena;
	logic	[31:0]	dmem_addr;
	logic	[31:0]	dmem_dout;
	logic	[31:0]	dmem_din;
	logic			dmem_ena;
	logic	[3:0]	dmem_wen;

	logic	[31:0]	rom [256];
	logic	[31:0]	ram [64];
	logic	[31:0]	lfsr;
	logic	[31:0]	exp_addr [$];
	logic	[31:0]	exp_data [$];
	logic	[31:0]	got_addr [$];
	logic	[31:0]	got_data [$];
	logic	[3:0]	got_wen [$];
	int				errors;
	int				tests;
	int				failed;

	`include "tb_model.svh"

	core_pipeline DUT (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_din(imem_din),
		.imem_ena(imem_ena),
		.dmem_addr(dmem_addr),
		.dmem_dout(dmem_dout),
		.dmem_din(dmem_din),
		.dmem_ena(dmem_ena),
		.dmem_wen(dmem_wen)
	);

	always #20 clk = !clk;

	// memories, one cycle read
	always @(posedge clk) begin
		if (imem_ena)
			imem_din <= rom[imem_addr[9:2]];
		if (dmem_ena) begin
			dmem_din <= ram[dmem_addr[7:2]];
			if (dmem_wen != 4'h0)
				ram[dmem_addr[7:2]] <= dmem_dout;
		end
		if (!reset && dmem_ena && dmem_wen != 4'h0) begin
			got_addr.push_back(dmem_addr);
			got_data.push_back(dmem_dout);
			got_wen.push_back(dmem_wen);
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic run_test(input string name, input int mode);
		int start_errors;
		int cycles;
		start_errors = errors;
		@(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		gen_program(mode);
		for (int i = 0; i < 64; i++)
			ram[i] = fill_word(6'(i));
		run_model();
		repeat (8) @(posedge clk);
		got_addr.delete();
		got_data.delete();
		got_wen.delete();
		reset <= 1'b0;

		cycles = 0;
		while (got_addr.size() < exp_addr.size() && cycles < 3000) begin
			@(posedge clk);
			cycles++;
		end
		if (got_addr.size() < exp_addr.size()) begin
			$display("%s: program never reached its end (%0d of %0d stores)", name,
				got_addr.size(), exp_addr.size());
			errors++;
		end else begin
			repeat (4) @(posedge clk);	// catch stray stores
			check("store count", 32'(got_addr.size()), 32'(exp_addr.size()));
			for (int i = 0; i < exp_addr.size(); i++) begin
				check("dmem_addr", got_addr[i], exp_addr[i]);
				check("dmem_dout", got_data[i], exp_data[i]);
				check("dmem_wen", {28'b0, got_wen[i]}, 32'h0000_000F);
			end
		end

		if (mode == M_MIX) begin
			// run it again, reset lands in the middle of the register dump
			reset <= 1'b1;
			repeat (2) @(posedge clk);
			for (int i = 0; i < 64; i++)
				ram[i] = fill_word(6'(i));
			got_addr.delete();
			got_data.delete();
			got_wen.delete();
			reset <= 1'b0;
			cycles = 0;
			while (got_addr.size() < exp_addr.size() - 16 && cycles < 3000) begin
				@(posedge clk);
				cycles++;
			end
			if (got_addr.size() < exp_addr.size() - 16) begin
				$display("%s: rerun never reached the register dump", name);
				errors++;
			end
			reset <= 1'b1;
			@(posedge clk);
			@(negedge clk);
			check("dmem_ena", {31'b0, dmem_ena}, 32'h0);
			check("dmem_wen", {28'b0, dmem_wen}, 32'h0);
		end

		tests++;
		if (errors == start_errors) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s FAILED with %0d errors", name, errors - start_errors);
			failed++;
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		imem_din = '0;
		dmem_din = '0;
		lfsr = 32'd59;
		errors = 0;
		tests = 0;
		failed = 0;
		repeat (10) @(posedge clk);

		run_test("alu_imm", M_ALU);
		run_test("back_to_back", M_DEP);
		run_test("load_use", M_LOAD);
		run_test("control_flow", M_CTRL);
		for (int n = 0; n < 10; n++)
			run_test($sformatf("mixed_%0d", n), M_MIX);

		$display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
+incdir+verif
src/isa_pkg.sv
src/pipe_pkg.sv
src/stage_ifs.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/core_pipeline.sv
verif/tb_core.sv

// File: run.sh
#!/bin/bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_core -o sim_core
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
	exit 0
fi
exit 1
